// ==== Makefile ====
all: run

obj_dir/Vtb_decode_stage: decode_stage.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage -f decode_stage.f

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tb_decode_stage -f decode_stage.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== decode_pkg.sv ====
// decode stage shared types: fetch entry, decoded micro-instruction, operations, opcodes
package decode_pkg;

	// major opcodes, bits [6:0] of a 32-bit instruction
	localparam logic [6:0] opc_load      = 7'b0000011;
	localparam logic [6:0] opc_misc_mem  = 7'b0001111;
	localparam logic [6:0] opc_op_imm    = 7'b0010011;
	localparam logic [6:0] opc_auipc     = 7'b0010111;
	localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
	localparam logic [6:0] opc_store     = 7'b0100011;
	localparam logic [6:0] opc_op        = 7'b0110011;
	localparam logic [6:0] opc_lui       = 7'b0110111;
	localparam logic [6:0] opc_op_32     = 7'b0111011;
	localparam logic [6:0] opc_branch    = 7'b1100011;
	localparam logic [6:0] opc_jalr      = 7'b1100111;
	localparam logic [6:0] opc_jal       = 7'b1101111;
	localparam logic [6:0] opc_system    = 7'b1110011;

	// one value per recognised instruction
	typedef enum logic [6:0] {
		op_illegal,
		op_lui, op_auipc, op_jal, op_jalr,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
		op_sb, op_sh, op_sw, op_sd,
		op_addi, op_addiw, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_slliw, op_srli, op_srliw, op_srai, op_sraiw,
		op_add, op_addw, op_sub, op_subw, op_sll, op_sllw,
		op_slt, op_sltu, op_xor, op_srl, op_srlw, op_sra, op_sraw,
		op_or, op_and,
		op_fence, op_fence_i,
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
		op_ecall, op_ebreak, op_mret,
		op_mul, op_mulh, op_mulhsu, op_mulhu,
		op_div, op_divu, op_rem, op_remu,
		op_mulw, op_divw, op_divuw, op_remw, op_remuw
	} instr_op_t;

	// what fetch hands over, is_rvc already set for expanded words
	typedef struct packed {
		logic [31:0] instr;
		logic [63:0] pc;
		logic        is_rvc;
	} fetch_entry_t;

	// decoded micro-instruction as seen by issue
	typedef struct packed {
		instr_op_t   op;
		logic [63:0] imm;
		logic [63:0] pc;
		logic [5:0]  shamt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic        is_rvc;
		logic        illegal;
		logic        access_fault;
	} decode_info_t;

endpackage

// ==== decode_stage.f ====
+incdir+.
decode_pkg.sv
sync_fifo.sv
decoder32.sv
decode_stage.sv
tb_decode_stage.sv

// ==== decode_stage.sv ====
// decode stage top: fetch queue, instruction decoder and decoded micro-instruction queue
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; #(
	parameter int FETCH_DEPTH = 4,
	parameter int UOP_DEPTH   = 4
) (
	input  logic         clk,
	input  logic         reset,

	// fetch side
	input  logic         fetch_push,
	input  fetch_entry_t fetch_entry,
	output logic         fetch_full,

	// issue side
	input  logic         uop_pop,
	output decode_info_t uop_info,
	output logic         uop_empty
);

	fetch_entry_t fetch_head;
	decode_info_t dec_info;
	logic         fetch_empty;
	logic         uop_full;
	logic         xfer;

	// move one entry per cycle whenever there is one and room for it
	assign xfer = !fetch_empty && !uop_full;

	sync_fifo #(
		.DEPTH     (FETCH_DEPTH),
		.payload_t (fetch_entry_t)
	) u_fetch_q (
		.clk       (clk),
		.reset     (reset),
		.push      (fetch_push),
		.push_data (fetch_entry),
		.pop       (xfer),
		.head      (fetch_head),
		.full      (fetch_full),
		.empty     (fetch_empty)
	);

	// decodes the fetch queue head in the same cycle it is transferred
	decoder32 u_decoder (
		.fetch (fetch_head),
		.info  (dec_info)
	);

	sync_fifo #(
		.DEPTH     (UOP_DEPTH),
		.payload_t (decode_info_t)
	) u_uop_q (
		.clk       (clk),
		.reset     (reset),
		.push      (xfer),
		.push_data (dec_info),
		.pop       (uop_pop),
		.head      (uop_info),
		.full      (uop_full),
		.empty     (uop_empty)
	);

endmodule

// ==== decoder32.sv ====
// combinational RV64IM + Zicsr + Zifencei instruction decoder
`timescale 1ns/1ps

module decoder32 import decode_pkg::*; (
	input  fetch_entry_t fetch,
	output decode_info_t info
);

	typedef enum logic [2:0] {
		fmt_none,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} imm_fmt_t;

	localparam logic [31:0] mret_word = 32'h30200073;

	logic [31:0] instr;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [63:0] imm_i;
	logic [63:0] imm_s;
	logic [63:0] imm_b;
	logic [63:0] imm_u;
	logic [63:0] imm_j;
	logic [63:0] imm;
	instr_op_t   op;
	imm_fmt_t    fmt;
	logic        zero_rd;

	assign instr  = fetch.instr;
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	// all immediates sign-extend from bit 31
	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		op  = op_illegal;
		fmt = fmt_none;
		case (opcode)
			opc_lui: begin
				op  = op_lui;
				fmt = fmt_u;
			end
			opc_auipc: begin
				op  = op_auipc;
				fmt = fmt_u;
			end
			opc_jal: begin
				op  = op_jal;
				fmt = fmt_j;
			end
			opc_jalr: begin
				fmt = fmt_i;
				if (funct3 == 3'b000) op = op_jalr;
			end
			opc_branch: begin
				fmt = fmt_b;
				case (funct3)
					3'b000:  op = op_beq;
					3'b001:  op = op_bne;
					3'b100:  op = op_blt;
					3'b101:  op = op_bge;
					3'b110:  op = op_bltu;
					3'b111:  op = op_bgeu;
					default: op = op_illegal;
				endcase
			end
			opc_load: begin
				fmt = fmt_i;
				case (funct3)
					3'b000:  op = op_lb;
					3'b001:  op = op_lh;
					3'b010:  op = op_lw;
					3'b011:  op = op_ld;
					3'b100:  op = op_lbu;
					3'b101:  op = op_lhu;
					3'b110:  op = op_lwu;
					default: op = op_illegal;
				endcase
			end
			opc_store: begin
				fmt = fmt_s;
				case (funct3)
					3'b000:  op = op_sb;
					3'b001:  op = op_sh;
					3'b010:  op = op_sw;
					3'b011:  op = op_sd;
					default: op = op_illegal;
				endcase
			end
			opc_op_imm: begin
				fmt = fmt_i;
				// 64-bit shifts use funct7[0] as shamt[5]
				case (funct3)
					3'b000: op = op_addi;
					3'b010: op = op_slti;
					3'b011: op = op_sltiu;
					3'b100: op = op_xori;
					3'b110: op = op_ori;
					3'b111: op = op_andi;
					3'b001: if (funct7[6:1] == 6'b000000) op = op_slli;
					3'b101: begin
						if (funct7[6:1] == 6'b000000) op = op_srli;
						else if (funct7[6:1] == 6'b010000) op = op_srai;
					end
					default: op = op_illegal;
				endcase
			end
			opc_op_imm_32: begin
				fmt = fmt_i;
				case (funct3)
					3'b000: op = op_addiw;
					3'b001: if (funct7 == 7'b0000000) op = op_slliw;
					3'b101: begin
						if (funct7 == 7'b0000000) op = op_srliw;
						else if (funct7 == 7'b0100000) op = op_sraiw;
					end
					default: op = op_illegal;
				endcase
			end
			opc_op: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: op = op_add;
						3'b001: op = op_sll;
						3'b010: op = op_slt;
						3'b011: op = op_sltu;
						3'b100: op = op_xor;
						3'b101: op = op_srl;
						3'b110: op = op_or;
						3'b111: op = op_and;
					endcase
				end else if (funct7 == 7'b0100000) begin
					if (funct3 == 3'b000) op = op_sub;
					else if (funct3 == 3'b101) op = op_sra;
				end else if (funct7 == 7'b0000001) begin
					// M extension
					case (funct3)
						3'b000: op = op_mul;
						3'b001: op = op_mulh;
						3'b010: op = op_mulhsu;
						3'b011: op = op_mulhu;
						3'b100: op = op_div;
						3'b101: op = op_divu;
						3'b110: op = op_rem;
						3'b111: op = op_remu;
					endcase
				end
			end
			opc_op_32: begin
				if (funct7 == 7'b0000000) begin
					if (funct3 == 3'b000) op = op_addw;
					else if (funct3 == 3'b001) op = op_sllw;
					else if (funct3 == 3'b101) op = op_srlw;
				end else if (funct7 == 7'b0100000) begin
					if (funct3 == 3'b000) op = op_subw;
					else if (funct3 == 3'b101) op = op_sraw;
				end else if (funct7 == 7'b0000001) begin
					case (funct3)
						3'b000:  op = op_mulw;
						3'b100:  op = op_divw;
						3'b101:  op = op_divuw;
						3'b110:  op = op_remw;
						3'b111:  op = op_remuw;
						default: op = op_illegal;
					endcase
				end
			end
			opc_misc_mem: begin
				fmt = fmt_i;
				if (funct3 == 3'b000) op = op_fence;
				else if (funct3 == 3'b001) op = op_fence_i;
			end
			opc_system: begin
				// csr forms carry the csr address in the I immediate
				fmt = fmt_i;
				case (funct3)
					3'b000: begin
						fmt = fmt_none;
						if (instr == mret_word) op = op_mret;
						else if (instr[31:20] == 12'h000) op = op_ecall;
						else if (instr[31:20] == 12'h001) op = op_ebreak;
					end
					3'b001:  op = op_csrrw;
					3'b010:  op = op_csrrs;
					3'b011:  op = op_csrrc;
					3'b101:  op = op_csrrwi;
					3'b110:  op = op_csrrsi;
					3'b111:  op = op_csrrci;
					default: op = op_illegal;
				endcase
			end
			default: op = op_illegal;
		endcase
		// nothing recognised, no immediate
		if (op == op_illegal) fmt = fmt_none;
	end

	always_comb begin
		case (fmt)
			fmt_i:   imm = imm_i;
			fmt_s:   imm = imm_s;
			fmt_b:   imm = imm_b;
			fmt_u:   imm = imm_u;
			fmt_j:   imm = imm_j;
			default: imm = '0;
		endcase
	end

	// these write no register
	assign zero_rd = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_sb, op_sh, op_sw, op_sd, op_fence, op_fence_i, op_ecall, op_ebreak};

	always_comb begin
		info.op           = op;
		info.imm          = imm;
		info.pc           = fetch.pc;
		info.shamt        = instr[25:20];
		info.rd           = zero_rd ? 5'd0 : rd;
		info.rs1          = rs1;
		info.rs2          = rs2;
		info.is_rvc       = fetch.is_rvc;
		info.illegal      = (op == op_illegal);
		info.access_fault = 1'b0;
	end

endmodule

// ==== sync_fifo.sv ====
// synchronous circular queue with a generic payload, push/pop strobes and full/empty levels
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = $clog2(DEPTH);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// strobes are qualified here as well, callers normally gate them already
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (count == (PTR_W + 1)'(DEPTH));
	assign empty = (count == '0);

	// head comes straight from storage, no extra register stage
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// depth is a power of two so pointers wrap on their own
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== tb_decode_model.svh ====
// decode reference model: instruction encoders and expected decoded results
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc,
	logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc,
	logic [4:0] rd, logic [4:0] rs1);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [2:0] f3,
	logic [4:0] rs1, logic [4:0] rs2);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
endfunction

// bit 0 of a branch offset is never encoded
function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3,
	logic [4:0] rs1, logic [4:0] rs2);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [6:0] opc, logic [4:0] rd);
	return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

// sign-extend the low bits of v to 64 bits
function automatic logic [63:0] sext(logic [63:0] v, int bits);
	return 64'($signed(v << (64 - bits)) >>> (64 - bits));
endfunction

// expected bundle, register fields and shamt come straight from the word
function automatic decode_info_t make_exp(logic [31:0] w, instr_op_t op, logic [63:0] imm,
	logic zero_rd, logic [63:0] pc, logic rvc);
	decode_info_t d;
	d.op           = op;
	d.imm          = imm;
	d.pc           = pc;
	d.shamt        = w[25:20];
	d.rd           = zero_rd ? 5'd0 : w[11:7];
	d.rs1          = w[19:15];
	d.rs2          = w[24:20];
	d.is_rvc       = rvc;
	d.illegal      = (op == op_illegal);
	d.access_fault = 1'b0;
	return d;
endfunction

`endif

// ==== tb_decode_stage.sv ====
// decode stage testbench: random encodings checked against the reference model
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

	logic         clk;
	logic         reset;
	logic         fetch_push;
	fetch_entry_t fetch_entry;
	logic         fetch_full;
	logic         uop_pop;
	decode_info_t uop_info;
	logic         uop_empty;

	int           errors;
	int           test_errors;
	int           checks;
	logic         sign_bit;
	logic [63:0]  pc_next;
	decode_info_t exp_q[$];

	decode_stage u_dut (
		.clk         (clk),
		.reset       (reset),
		.fetch_push  (fetch_push),
		.fetch_entry (fetch_entry),
		.fetch_full  (fetch_full),
		.uop_pop     (uop_pop),
		.uop_info    (uop_info),
		.uop_empty   (uop_empty)
	);

	`include "tb_decode_model.svh"

	initial begin
		clk = 1'b0;
		forever #4 clk = !clk;
	end

	// no access fault can come out of this stage
	assert property (@(posedge clk) disable iff (reset) !uop_empty |-> !uop_info.access_fault)
		else begin
			$display("CHECK FAILED: access_fault got %h expected %h", 1'b1, 1'b0);
			errors++;
		end

	task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_info(input decode_info_t exp);
		check_field("uop_info.op", 64'(uop_info.op), 64'(exp.op));
		check_field("uop_info.imm", uop_info.imm, exp.imm);
		check_field("uop_info.pc", uop_info.pc, exp.pc);
		check_field("uop_info.shamt", 64'(uop_info.shamt), 64'(exp.shamt));
		check_field("uop_info.rd", 64'(uop_info.rd), 64'(exp.rd));
		check_field("uop_info.rs1", 64'(uop_info.rs1), 64'(exp.rs1));
		check_field("uop_info.rs2", 64'(uop_info.rs2), 64'(exp.rs2));
		check_field("uop_info.is_rvc", 64'(uop_info.is_rvc), 64'(exp.is_rvc));
		check_field("uop_info.illegal", 64'(uop_info.illegal), 64'(exp.illegal));
		check_field("uop_info.access_fault", 64'(uop_info.access_fault), 64'(exp.access_fault));
	endtask

	// sets up the entry on the fetch port and records what should come out
	task automatic stage_entry(input logic [31:0] w, input instr_op_t op, input logic [63:0] imm,
		input logic zr);
		fetch_entry_t e;
		e.instr  = w;
		e.pc     = pc_next;
		e.is_rvc = 1'($urandom);
		exp_q.push_back(make_exp(w, op, imm, zr, e.pc, e.is_rvc));
		pc_next     = pc_next + (e.is_rvc ? 64'd2 : 64'd4);
		fetch_entry = e;
	endtask

	task automatic push_entry(input logic [31:0] w, input instr_op_t op, input logic [63:0] imm,
		input logic zr);
		int t;
		t = 0;
		while (fetch_full && t < 100) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (fetch_full) begin
			$display("timeout: fetch queue never had room for a push");
			test_errors++;
			return;
		end
		stage_entry(w, op, imm, zr);
		fetch_push = 1'b1;
		@(posedge clk);
		#1;
		fetch_push = 1'b0;
	endtask

	task automatic pop_check();
		int t;
		t = 0;
		while (uop_empty && t < 100) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (uop_empty) begin
			$display("timeout: no decoded instruction arrived");
			test_errors++;
			return;
		end
		if (exp_q.size() == 0) begin
			$display("a decoded instruction arrived that was never pushed");
			test_errors++;
			return;
		end
		compare_info(exp_q.pop_front());
		uop_pop = 1'b1;
		@(posedge clk);
		#1;
		uop_pop = 1'b0;
	endtask

	task automatic send(input logic [31:0] w, input instr_op_t op, input logic [63:0] imm,
		input logic zr);
		push_entry(w, op, imm, zr);
		pop_check();
	endtask

	task automatic send_r(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] opc,
		input instr_op_t op);
		send(enc_r(f7, f3, opc, 5'($urandom), 5'($urandom), 5'($urandom)), op, 64'd0, 1'b0);
	endtask

	task automatic send_i(input logic [2:0] f3, input logic [6:0] opc, input instr_op_t op,
		input logic zr);
		logic [11:0] imm;
		imm      = 12'($urandom);
		imm[11]  = sign_bit;
		sign_bit = !sign_bit;
		send(enc_i(imm, f3, opc, 5'($urandom), 5'($urandom)), op, sext(64'(imm), 12), zr);
	endtask

	task automatic send_s(input logic [2:0] f3, input instr_op_t op);
		logic [11:0] imm;
		imm      = 12'($urandom);
		imm[11]  = sign_bit;
		sign_bit = !sign_bit;
		send(enc_s(imm, f3, 5'($urandom), 5'($urandom)), op, sext(64'(imm), 12), 1'b1);
	endtask

	task automatic send_b(input logic [2:0] f3, input instr_op_t op);
		logic [12:0] imm;
		imm      = 13'($urandom);
		imm[0]   = 1'b0;
		imm[12]  = sign_bit;
		sign_bit = !sign_bit;
		send(enc_b(imm, f3, 5'($urandom), 5'($urandom)), op, sext(64'(imm), 13), 1'b1);
	endtask

	task automatic send_uj(input logic [6:0] opc, input instr_op_t op);
		logic [20:0] imm;
		imm      = 21'($urandom);
		imm[0]   = 1'b0;
		imm[20]  = sign_bit;
		sign_bit = !sign_bit;
		if (opc == opc_jal)
			send(enc_j(imm, 5'($urandom)), op, sext(64'(imm), 21), 1'b0);
		else
			send(enc_u(imm[20:1], opc, 5'($urandom)), op, sext(64'({imm[20:1], 12'h000}), 32),
				1'b0);
	endtask

	// random push and pop every cycle, head compared whenever it is popped
	task automatic stream_random(input int n);
		int pushed;
		int cyc;
		logic do_push;
		logic do_pop;
		logic [11:0] imm;
		pushed = 0;
		cyc    = 0;
		while ((pushed < n || exp_q.size() > 0) && cyc < 20000) begin
			do_pop  = !uop_empty && ($urandom % 3 != 0);
			do_push = (pushed < n) && !fetch_full && ($urandom % 4 != 0);
			if (do_pop) compare_info(exp_q.pop_front());
			if (do_push) begin
				imm = 12'($urandom);
				stage_entry(enc_i(imm, 3'd0, opc_op_imm, 5'($urandom), 5'($urandom)), op_addi,
					sext(64'(imm), 12), 1'b0);
				pushed++;
			end
			fetch_push = do_push;
			uop_pop    = do_pop;
			@(posedge clk);
			#1;
			cyc++;
		end
		fetch_push = 1'b0;
		uop_pop    = 1'b0;
		if (cyc >= 20000) begin
			$display("timeout: streaming did not drain all instructions");
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		errors      = errors + test_errors;
		test_errors = 0;
	endtask

	initial begin
		logic [5:0] sh;
		void'($urandom(43338));
		errors      = 0;
		test_errors = 0;
		checks      = 0;
		sign_bit    = 1'b0;
		pc_next     = 64'h8000_0000;
		reset       = 1'b1;
		fetch_push  = 1'b0;
		fetch_entry = '0;
		uop_pop     = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		check_field("uop_empty", 64'(uop_empty), 64'd1);
		check_field("fetch_full", 64'(fetch_full), 64'd0);
		push_entry(enc_r(7'h00, 3'd0, opc_op, 5'd1, 5'd2, 5'd3), op_add, 64'd0, 1'b0);
		// one edge after the push edge nothing is out yet
		check_field("uop_empty", 64'(uop_empty), 64'd1);
		@(posedge clk);
		#1;
		check_field("uop_empty", 64'(uop_empty), 64'd0);
		pop_check();
		finish_test("reset and latency");

		repeat (4) begin
			send_r(7'h00, 3'd0, opc_op, op_add);
			send_r(7'h20, 3'd0, opc_op, op_sub);
			send_r(7'h20, 3'd5, opc_op, op_sra);
			send_r(7'h00, 3'd3, opc_op, op_sltu);
			send_r(7'h00, 3'd7, opc_op, op_and);
			send_r(7'h20, 3'd0, opc_op_32, op_subw);
			send_r(7'h00, 3'd1, opc_op_32, op_sllw);
			send_r(7'h01, 3'd0, opc_op, op_mul);
			send_r(7'h01, 3'd2, opc_op, op_mulhsu);
			send_r(7'h01, 3'd7, opc_op, op_remu);
			send_r(7'h01, 3'd5, opc_op_32, op_divuw);
			send_i(3'd4, opc_op_imm, op_xori, 1'b0);
			send_i(3'd1, opc_system, op_csrrw, 1'b0);
			send_i(3'd7, opc_system, op_csrrci, 1'b0);
			sh = 6'($urandom);
			send(enc_i({6'h00, sh}, 3'd1, opc_op_imm, 5'($urandom), 5'($urandom)), op_slli,
				64'(sh), 1'b0);
			send(enc_i({6'h10, sh}, 3'd5, opc_op_imm, 5'($urandom), 5'($urandom)), op_srai,
				64'h400 | 64'(sh), 1'b0);
		end
		send(32'h00000073, op_ecall, 64'd0, 1'b1);
		send(32'h00100073, op_ebreak, 64'd0, 1'b1);
		send(32'h30200073, op_mret, 64'd0, 1'b0);
		send_i(3'd0, opc_misc_mem, op_fence, 1'b1);
		send_i(3'd1, opc_misc_mem, op_fence_i, 1'b1);
		finish_test("register and operation decoding");

		repeat (8) begin
			send_i(3'd3, opc_load, op_ld, 1'b0);
			send_i(3'd0, opc_jalr, op_jalr, 1'b0);
			send_i(3'd0, opc_op_imm_32, op_addiw, 1'b0);
			send_s(3'd2, op_sw);
			send_s(3'd3, op_sd);
			send_b(3'd0, op_beq);
			send_b(3'd7, op_bgeu);
			send_uj(opc_lui, op_lui);
			send_uj(opc_auipc, op_auipc);
			send_uj(opc_jal, op_jal);
			// an odd number of sign flips per pass gives every call both signs
			sign_bit = !sign_bit;
		end
		finish_test("immediates");

		send(32'h00000053 | 32'($urandom) & 32'hffff_ff80, op_illegal, 64'd0, 1'b0);
		send(32'h00000007 | 32'($urandom) & 32'hffff_ff80, op_illegal, 64'd0, 1'b0);
		send(enc_r(7'h02, 3'd0, opc_op, 5'($urandom), 5'($urandom), 5'($urandom)), op_illegal,
			64'd0, 1'b0);
		send(32'h00000000, op_illegal, 64'd0, 1'b0);
		finish_test("illegal detection");

		repeat (8) begin
			push_entry(enc_r(7'h00, 3'd6, opc_op, 5'($urandom), 5'($urandom), 5'($urandom)),
				op_or, 64'd0, 1'b0);
		end
		check_field("fetch_full", 64'(fetch_full), 64'd1);
		repeat (8) pop_check();
		check_field("uop_empty", 64'(uop_empty), 64'd1);
		finish_test("back-pressure and order");

		stream_random(400);
		check_field("uop_empty", 64'(uop_empty), 64'd1);
		finish_test("streaming");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
